// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ns
TOP = i8008_core_tb
FILELIST = sim.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/i8008_alu.sv
`timescale 1ns/1ns

module i8008_alu
	import i8008_isa_pkg::*;
	import i8008_bus_pkg::*;
(
	input logic clk,
	input logic rst,
	input ctrl_t ctrl,
	input logic [data_w-1:0] temp_a,
	input logic [data_w-1:0] temp_b,
	output logic [data_w-1:0] alu_result
);

	logic carry;
	logic carry_next;
	logic [data_w:0] cin_ext;

	assign cin_ext = {{data_w{1'b0}}, carry};

	always_comb begin
		alu_result = '0;
		carry_next = carry;
		if (ctrl.alu_unary) begin
			case (ctrl.unary_op)
				rlc: begin
					alu_result = {temp_a[data_w-2:0], temp_a[data_w-1]};
					carry_next = temp_a[data_w-1];
				end
				rrc: begin
					alu_result = {temp_a[0], temp_a[data_w-1:1]};
					carry_next = temp_a[0];
				end
				ral: begin
					alu_result = {temp_a[data_w-2:0], carry}; // Rotate through carry
					carry_next = temp_a[data_w-1];
				end
				rar: begin
					alu_result = {carry, temp_a[data_w-1:1]};
					carry_next = temp_a[0];
				end
				inc: alu_result = temp_a + 1'b1;
				dec: alu_result = temp_a - 1'b1;
				default: ;
			endcase
		end else begin
			case (ctrl.alu_op)
				add: {carry_next, alu_result} = {1'b0, temp_a} + {1'b0, temp_b};
				adc: {carry_next, alu_result} = {1'b0, temp_a} + {1'b0, temp_b} + cin_ext;
				sub: {carry_next, alu_result} = {1'b0, temp_a} - {1'b0, temp_b}; // Bit 8 is borrow
				sbb: {carry_next, alu_result} = {1'b0, temp_a} - {1'b0, temp_b} - cin_ext;
				and_op: begin
					alu_result = temp_a & temp_b;
					carry_next = 1'b0;
				end
				xor_op: begin
					alu_result = temp_a ^ temp_b;
					carry_next = 1'b0;
				end
				or_op: begin
					alu_result = temp_a | temp_b;
					carry_next = 1'b0;
				end
				default: begin
					alu_result = temp_a; // CMP leaves A on the bus
					carry_next = (temp_a < temp_b);
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			carry <= 1'b0;
		else if (ctrl.carry_we)
			carry <= carry_next;
	end

endmodule

// File: design/i8008_bus_pkg.sv
package i8008_bus_pkg;
	import i8008_isa_pkg::*;

	typedef enum logic [2:0] {
		t1 = 3'b010,
		t2 = 3'b100,
		tw = 3'b000,
		t3 = 3'b001,
		t4 = 3'b111,
		t5 = 3'b101
	} tstate_t;

	// Cycle type in bits 7..6 of the T2 byte
	localparam logic [1:0] cyc_fetch = 2'b00;

	typedef struct packed {
		logic sync;
		logic pc_lo_out;
		logic pc_hi_out;
		logic pc_inc;
		logic ir_we;
		logic din_out;
		logic rf_out;
		logic rf_we;
		reg_idx_t rf_sel;
		logic acc_to_a; // temp_a source is A, not the bus
		logic a_we;
		logic b_we;
		logic b_out;
		logic alu_out;
		logic alu_unary;
		alu_op_t alu_op;
		unary_op_t unary_op;
		logic carry_we;
	} ctrl_t;

endpackage

// File: design/i8008_core.sv
`timescale 1ns/1ns

module i8008_core
	import i8008_isa_pkg::*;
	import i8008_bus_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic [data_w-1:0] d_in,
	input logic ready,
	output logic [data_w-1:0] d_out,
	output logic sync,
	output tstate_t state
);

	ctrl_t ctrl;
	logic [data_w-1:0] instr;
	logic [data_w-1:0] temp_a;
	logic [data_w-1:0] temp_b;
	logic [data_w-1:0] rf_data;
	logic [data_w-1:0] acc;
	logic [data_w-1:0] alu_result;

	assign sync = ctrl.sync;

	i8008_tstate_seq seq_i (
		.clk(clk),
		.rst(rst),
		.ready(ready),
		.state(state)
	);

	i8008_decoder dec_i (
		.state(state),
		.instr(instr),
		.ctrl(ctrl)
	);

	i8008_datapath dp_i (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl),
		.d_in(d_in),
		.rf_data(rf_data),
		.acc(acc),
		.alu_result(alu_result),
		.instr(instr),
		.bus(d_out), // Output pins show the internal bus
		.temp_a(temp_a),
		.temp_b(temp_b)
	);

	i8008_reg_file rf_i (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl),
		.bus(d_out),
		.rf_data(rf_data),
		.acc(acc)
	);

	i8008_alu alu_i (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl),
		.temp_a(temp_a),
		.temp_b(temp_b),
		.alu_result(alu_result)
	);

endmodule

// File: design/i8008_datapath.sv
`timescale 1ns/1ns

module i8008_datapath
	import i8008_isa_pkg::*;
	import i8008_bus_pkg::*;
(
	input logic clk,
	input logic rst,
	input ctrl_t ctrl,
	input logic [data_w-1:0] d_in,
	input logic [data_w-1:0] rf_data,
	input logic [data_w-1:0] acc,
	input logic [data_w-1:0] alu_result,
	output logic [data_w-1:0] instr,
	output logic [data_w-1:0] bus,
	output logic [data_w-1:0] temp_a,
	output logic [data_w-1:0] temp_b
);

	logic [pc_w-1:0] pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			instr <= '0;
			temp_a <= '0;
			temp_b <= '0;
		end else begin
			if (ctrl.pc_inc)
				pc <= pc + 1'b1;
			if (ctrl.ir_we)
				instr <= d_in;
			if (ctrl.a_we)
				temp_a <= ctrl.acc_to_a ? acc : bus;
			if (ctrl.b_we)
				temp_b <= bus;
		end
	end

	// Internal bus, first enabled source wins
	always_comb begin
		if (ctrl.pc_lo_out)
			bus = pc[data_w-1:0];
		else if (ctrl.pc_hi_out)
			bus = {cyc_fetch, pc[pc_w-1:data_w]}; // Cycle type in top two bits
		else if (ctrl.rf_out)
			bus = rf_data;
		else if (ctrl.alu_out)
			bus = alu_result;
		else if (ctrl.b_out)
			bus = temp_b;
		else if (ctrl.din_out)
			bus = d_in;
		else
			bus = '0;
	end

endmodule

// File: design/i8008_decoder.sv
`timescale 1ns/1ns

module i8008_decoder
	import i8008_isa_pkg::*;
	import i8008_bus_pkg::*;
(
	input tstate_t state,
	input logic [data_w-1:0] instr,
	output ctrl_t ctrl
);

	op_class_t cls;
	reg_idx_t ddd;
	reg_idx_t sss;

	assign cls = op_class(instr);
	assign ddd = instr[5:3];
	assign sss = instr[2:0];

	always_comb begin
		ctrl = '0;
		case (state)
			t1: begin
				ctrl.sync = 1'b1;
				ctrl.pc_lo_out = 1'b1;
				ctrl.acc_to_a = 1'b1; // A into temp_a for ALU and rotates
				ctrl.a_we = 1'b1;
			end
			t2: begin
				ctrl.sync = 1'b1;
				ctrl.pc_hi_out = 1'b1;
				ctrl.pc_inc = 1'b1;
			end
			t3: begin
				ctrl.din_out = 1'b1;
				ctrl.ir_we = 1'b1;
			end
			t4: begin
				case (cls)
					op_mov, op_alu: begin
						ctrl.rf_out = 1'b1;
						ctrl.rf_sel = sss;
						ctrl.b_we = 1'b1;
					end
					op_inr, op_dcr: begin
						ctrl.rf_out = 1'b1;
						ctrl.rf_sel = ddd;
						ctrl.a_we = 1'b1;
					end
					default: ;
				endcase
			end
			t5: begin
				case (cls)
					op_mov: begin
						ctrl.b_out = 1'b1;
						ctrl.rf_we = 1'b1;
						ctrl.rf_sel = ddd;
					end
					op_alu: begin
						ctrl.alu_out = 1'b1;
						ctrl.alu_op = alu_op_t'(instr[5:3]);
						ctrl.carry_we = 1'b1;
						ctrl.rf_sel = reg_a;
						ctrl.rf_we = (alu_op_t'(instr[5:3]) != cmp); // CMP only sets carry
					end
					op_inr, op_dcr: begin
						ctrl.alu_out = 1'b1;
						ctrl.alu_unary = 1'b1;
						ctrl.unary_op = (cls == op_inr) ? inc : dec;
						ctrl.rf_we = 1'b1;
						ctrl.rf_sel = ddd;
					end
					op_rot: begin
						ctrl.alu_out = 1'b1;
						ctrl.alu_unary = 1'b1;
						ctrl.unary_op = unary_op_t'({1'b0, instr[4:3]});
						ctrl.carry_we = 1'b1;
						ctrl.rf_we = 1'b1;
						ctrl.rf_sel = reg_a;
					end
					default: ;
				endcase
			end
			default: ; // TW drives nothing
		endcase
	end

endmodule

// File: design/i8008_isa_pkg.sv
package i8008_isa_pkg;

	localparam int data_w = 8;
	localparam int pc_w = 14;
	localparam int num_regs = 7; // A through L, no M

	typedef logic [2:0] reg_idx_t;

	localparam reg_idx_t reg_a = 3'd0;
	localparam reg_idx_t reg_b = 3'd1;
	localparam reg_idx_t reg_c = 3'd2;
	localparam reg_idx_t reg_d = 3'd3;
	localparam reg_idx_t reg_e = 3'd4;
	localparam reg_idx_t reg_h = 3'd5;
	localparam reg_idx_t reg_l = 3'd6;
	localparam reg_idx_t reg_m = 3'd7; // Memory operand, not supported

	// Opcode bits 5..3 of the 10ooosss group
	typedef enum logic [2:0] {
		add = 3'd0,
		adc = 3'd1,
		sub = 3'd2,
		sbb = 3'd3,
		and_op = 3'd4,
		xor_op = 3'd5,
		or_op = 3'd6,
		cmp = 3'd7
	} alu_op_t;

	typedef enum logic [2:0] {
		rlc = 3'd0,
		rrc = 3'd1,
		ral = 3'd2,
		rar = 3'd3,
		inc = 3'd4,
		dec = 3'd5
	} unary_op_t;

	typedef enum logic [2:0] {
		op_mov, // 11dddsss
		op_alu, // 10ooosss
		op_inr, // 00ddd000, ddd not 0
		op_dcr, // 00ddd001, ddd not 0
		op_rot, // 000rr010
		op_nop  // Anything else
	} op_class_t;

	function automatic op_class_t op_class(input logic [data_w-1:0] op);
		op_class_t cls;
		cls = op_nop;
		if (op[7:6] == 2'b11 && op[5:3] != reg_m && op[2:0] != reg_m)
			cls = op_mov;
		else if (op[7:6] == 2'b10 && op[2:0] != reg_m)
			cls = op_alu;
		else if (op[7:6] == 2'b00 && op[5:3] != 3'd0 && op[5:3] != reg_m && op[2:0] == 3'd0)
			cls = op_inr;
		else if (op[7:6] == 2'b00 && op[5:3] != 3'd0 && op[5:3] != reg_m && op[2:0] == 3'd1)
			cls = op_dcr;
		else if (op[7:5] == 3'b000 && op[2:0] == 3'b010)
			cls = op_rot;
		return cls;
	endfunction

endpackage

// File: design/i8008_reg_file.sv
`timescale 1ns/1ns

module i8008_reg_file
	import i8008_isa_pkg::*;
	import i8008_bus_pkg::*;
(
	input logic clk,
	input logic rst,
	input ctrl_t ctrl,
	input logic [data_w-1:0] bus,
	output logic [data_w-1:0] rf_data,
	output logic [data_w-1:0] acc
);

	logic [data_w-1:0] regs [0:num_regs-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < num_regs; i++)
				regs[i] <= '0;
		end else if (ctrl.rf_we && ctrl.rf_sel != reg_m) begin
			regs[ctrl.rf_sel] <= bus;
		end
	end

	// M has no storage here, reads fall back to A
	assign rf_data = (ctrl.rf_sel == reg_m) ? regs[reg_a] : regs[ctrl.rf_sel];
	assign acc = regs[reg_a];

endmodule

// File: design/i8008_tstate_seq.sv
`timescale 1ns/1ns

module i8008_tstate_seq
	import i8008_bus_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic ready,
	output tstate_t state
);

	logic ready_meta;
	logic ready_sync;
	tstate_t next_state;

	// Two flops on the asynchronous READY level
	always_ff @(posedge clk) begin
		ready_meta <= ready;
		ready_sync <= ready_meta;
	end

	always_comb begin
		case (state)
			t1: next_state = t2;
			t2, tw: next_state = ready_sync ? t3 : tw; // Wait until memory is ready
			t3: next_state = t4;
			t4: next_state = t5;
			default: next_state = t1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= t1;
		else
			state <= next_state;
	end

endmodule

// File: dv/i8008_core_properties.sv
`timescale 1ns/1ns

module i8008_core_properties
	import i8008_bus_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic sync,
	input tstate_t state
);

	// Address bytes go out in t1 and t2 only
	sync_in_t1_t2: assert property (@(posedge clk) disable iff (rst)
		sync == (state == t1 || state == t2))
		else $error("sync is %b in state %03b", sync, state);

	t3_then_t4: assert property (@(posedge clk) disable iff (rst)
		state == t3 |=> state == t4)
		else $error("t3 not followed by t4");

	t4_then_t5: assert property (@(posedge clk) disable iff (rst)
		state == t4 |=> state == t5)
		else $error("t4 not followed by t5");

	t5_then_t1: assert property (@(posedge clk) disable iff (rst)
		state == t5 |=> state == t1)
		else $error("t5 not followed by t1");

	legal_state: assert property (@(posedge clk) disable iff (rst)
		state inside {t1, t2, tw, t3, t4, t5})
		else $error("illegal state code %03b", state);

endmodule

bind i8008_core i8008_core_properties props_i (
	.clk(clk),
	.rst(rst),
	.sync(sync),
	.state(state)
);

// File: dv/i8008_core_tb.sv
`timescale 1ns/1ns

module i8008_core_tb
	import i8008_bus_pkg::*;
();

	localparam int clk_period = 8;
	localparam int num_rows = 28;
	localparam int max_wait = 8;
	localparam int timeout_clocks = 3 + num_rows * (5 + max_wait + 4);

	typedef struct packed {
		logic [7:0] op;
		logic [7:0] t4; // Source operand on the bus
		logic [7:0] t5; // Result on the bus
		logic hold; // Pull ready low ahead of this fetch
	} row_t;

	// Traced by hand from all registers and carry at zero
	localparam row_t rows [0:num_rows-1] = '{
		'{8'h08, 8'h00, 8'h01, 1'b0}, // INR B
		'{8'h08, 8'h01, 8'h02, 1'b1}, // INR B
		'{8'h11, 8'h00, 8'hff, 1'b0}, // DCR C, wraps to FF
		'{8'hc2, 8'hff, 8'hff, 1'b0}, // MOV A,C
		'{8'h81, 8'h02, 8'h01, 1'b0}, // ADD B, carry set
		'{8'h89, 8'h02, 8'h04, 1'b1}, // ADC B
		'{8'h92, 8'hff, 8'h05, 1'b0}, // SUB C, borrow set
		'{8'h99, 8'h02, 8'h02, 1'b0}, // SBB B
		'{8'hba, 8'hff, 8'h02, 1'b0}, // CMP C, A stays 02
		'{8'hb1, 8'h02, 8'h02, 1'b0}, // ORA B, carry cleared
		'{8'h0a, 8'h00, 8'h01, 1'b0}, // RRC
		'{8'h0a, 8'h00, 8'h80, 1'b1}, // RRC, carry set
		'{8'h12, 8'h00, 8'h01, 1'b0}, // RAL
		'{8'h1a, 8'h00, 8'h80, 1'b0}, // RAR
		'{8'h02, 8'h00, 8'h01, 1'b0}, // RLC
		'{8'ha2, 8'hff, 8'h01, 1'b0}, // ANA C
		'{8'h1a, 8'h00, 8'h00, 1'b0}, // RAR with carry clear
		'{8'hda, 8'hff, 8'hff, 1'b0}, // MOV D,C
		'{8'h18, 8'hff, 8'h00, 1'b0}, // INR D, carry kept
		'{8'h89, 8'h02, 8'h03, 1'b1}, // ADC B
		'{8'h21, 8'h00, 8'hff, 1'b0}, // DCR E
		'{8'hac, 8'hff, 8'hfc, 1'b0}, // XRA E
		'{8'h00, 8'h00, 8'h00, 1'b0}, // NOP
		'{8'hf1, 8'h02, 8'h02, 1'b0}, // MOV L,B
		'{8'hee, 8'h02, 8'h02, 1'b0}, // MOV H,L
		'{8'h95, 8'h02, 8'hfa, 1'b0}, // SUB H
		'{8'h9c, 8'hff, 8'hfb, 1'b0}, // SBB E
		'{8'h30, 8'h02, 8'h03, 1'b1} // INR L
	};

	logic clk;
	logic rst;
	logic [7:0] d_in = 8'h00;
	logic ready;
	logic [7:0] d_out;
	logic sync;
	tstate_t state;

	logic [7:0] addr_lo;
	logic [31:0] lfsr = 32'h2b7b;
	int hold_len [num_rows];
	int low_left;
	int errors;
	int checks;
	int row_errors;

	i8008_core dut_i (
		.clk(clk),
		.rst(rst),
		.d_in(d_in),
		.ready(ready),
		.d_out(d_out),
		.sync(sync),
		.state(state)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	function automatic logic [7:0] fetch_op(input logic [13:0] addr);
		int idx;
		idx = int'(addr);
		if (idx < num_rows)
			return rows[idx].op;
		return 8'h00; // Past the table, NOP
	endfunction

	// Program memory
	always @(negedge clk) begin
		if (state == t1)
			addr_lo <= d_out;
		else if (state == t2)
			d_in <= fetch_op({d_out[5:0], addr_lo});
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			row_errors++;
			$display("mismatch at %0t ns: %s is %02h, expected %02h", $time, name, got, exp);
		end
	endtask

	task automatic next_cycle();
		@(negedge clk);
		if (low_left > 0) begin
			ready = 1'b0;
			low_left--;
		end else begin
			ready = 1'b1;
		end
	endtask

	task automatic run_row(input int r);
		logic [13:0] pc;
		int tw_cnt;
		int tw_exp;
		pc = 14'(r);
		tw_exp = hold_len[r];
		row_errors = 0;
		check_value("state", {5'b0, state}, {5'b0, t1});
		check_value("d_out", d_out, pc[7:0]);
		check_value("sync", {7'b0, sync}, 8'h01);
		next_cycle();
		check_value("state", {5'b0, state}, {5'b0, t2});
		check_value("d_out", d_out, {2'b00, pc[13:8]}); // Fetch cycle type on top
		check_value("sync", {7'b0, sync}, 8'h01);
		tw_cnt = 0;
		next_cycle();
		while (state == tw) begin
			tw_cnt++;
			check_value("d_out", d_out, 8'h00);
			next_cycle();
		end
		check_value("state", {5'b0, state}, {5'b0, t3});
		check_value("d_out", d_out, rows[r].op);
		check_value("sync", {7'b0, sync}, 8'h00);
		check_value("tw count", tw_cnt[7:0], tw_exp[7:0]);
		next_cycle();
		check_value("state", {5'b0, state}, {5'b0, t4});
		check_value("d_out", d_out, rows[r].t4);
		next_cycle();
		check_value("state", {5'b0, state}, {5'b0, t5});
		check_value("d_out", d_out, rows[r].t5);
		// Two clocks of sync delay put this ahead of the next T2
		if (r + 1 < num_rows && rows[r + 1].hold) begin
			ready = 1'b0;
			low_left = hold_len[r + 1] - 1;
		end
		$display("row %0d op %02h tw %0d: %s", r, rows[r].op, tw_cnt,
			(row_errors == 0) ? "ok" : "failed");
		next_cycle();
	endtask

	initial begin
		rst = 1'b1;
		ready = 1'b1;
		low_left = 0;
		errors = 0;
		checks = 0;
		for (int i = 0; i < num_rows; i++) begin
			if (rows[i].hold) begin
				draw_bits(3, hold_len[i]);
				hold_len[i] = hold_len[i] + 1; // 1 to max_wait
			end else begin
				hold_len[i] = 0;
			end
		end
		repeat (3) @(negedge clk);
		rst = 1'b0;
		for (int r = 0; r < num_rows; r++)
			run_row(r);
		$display("%0d rows, %0d checks, %0d errors", num_rows, checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		#(timeout_clocks * clk_period);
		$display("timeout: the core did not get through all %0d rows in time", num_rows);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: sim.f
design/i8008_isa_pkg.sv
design/i8008_bus_pkg.sv
design/i8008_tstate_seq.sv
design/i8008_decoder.sv
design/i8008_alu.sv
design/i8008_reg_file.sv
design/i8008_datapath.sv
design/i8008_core.sv
dv/i8008_core_properties.sv
dv/i8008_core_tb.sv
